//--- Makefile
# Verilator simulation of the leaf elimination pipeline

LOG := sim.log
SIM := obj_dir/VleafEliminationTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM): sources.f rtl/*.sv test/*.sv test/*.svh
	verilator --binary --timing --assert -f sources.f \
		--top-module leafEliminationTb -Mdir obj_dir

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/leafElimPkg.sv
package leafElimPkg;

    // ------------------------------------------------------------------
    // hypercube geometry
    // ------------------------------------------------------------------

    localparam int dimCount   = 7;                // hypercube dimension
    localparam int graphWidth = 1 << dimCount;    // 128 vertices

    // one bit per vertex, bit i set when vertex i is present
    typedef logic [graphWidth-1:0] graphT;

    // ------------------------------------------------------------------
    // pipeline shape
    // ------------------------------------------------------------------

    localparam int pairCount  = 4;                // DOWN/UP pass pairs
    localparam int stageCount = 2 * pairCount;    // registered passes in total

    // which side of a vertex counts as the leaf side
    typedef enum logic {
        passDown,    // leaf hangs off one neighbor above
        passUp       // leaf hangs off one neighbor below
    } passDirT;

endpackage

//--- rtl/leafElimination.sv
module leafElimination #(
    parameter leafElimPkg::passDirT passDir = leafElimPkg::passDown
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stageEn,
    input  leafElimPkg::graphT graphIn,
    output leafElimPkg::graphT graphOut
);

    import leafElimPkg::*;

    // ------------------------------------------------------------------
    // elaboration helpers on vertex indices
    // ------------------------------------------------------------------

    // number of set bits in the low width bits of value
    function automatic int bitCount(input int value, input int width);
        int sum;
        sum = 0;
        for (int i = 0; i < width; i++) begin
            if (value[i]) begin
                sum++;
            end
        end
        return sum;
    endfunction

    // position of the n-th bit equal to bitValue, counted from bit 0
    function automatic int nthBit(input int value, input int n, input bit bitValue);
        int seen;
        int pos;
        seen = 0;
        pos  = 0;
        for (int i = 0; i < dimCount; i++) begin
            if (value[i] == bitValue) begin
                if (seen == n) begin
                    pos = i;
                end
                seen++;
            end
        end
        return pos;
    endfunction

    // ------------------------------------------------------------------
    // per-vertex decision
    // ------------------------------------------------------------------

    graphT graphNext;

    // the two fixed corners are never removed
    assign graphNext[0]            = graphIn[0];
    assign graphNext[graphWidth-1] = graphIn[graphWidth-1];

    for (genvar v = 1; v < graphWidth - 1; v++) begin : genVertex
        localparam int belowCount = bitCount(v, dimCount);
        localparam int aboveCount = dimCount - belowCount;

        logic [belowCount-1:0] belowBits;
        logic [aboveCount-1:0] aboveBits;

        // clear one set bit of the index
        for (genvar b = 0; b < belowCount; b++) begin : genBelow
            localparam int nbr = v & ~(1 << nthBit(v, b, 1'b1));
            assign belowBits[b] = graphIn[nbr];
        end

        // set one clear bit of the index
        for (genvar a = 0; a < aboveCount; a++) begin : genAbove
            localparam int nbr = v | (1 << nthBit(v, a, 1'b0));
            assign aboveBits[a] = graphIn[nbr];
        end

        if (passDir == passUp) begin : genUp
            leafEliminationElement #(
                .leafSideCount(belowCount)
            ) element (
                .vertexPresent     (graphIn[v]),
                .leafSideNeighbors (belowBits),
                .otherSideNeighbors(aboveBits),
                .keepVertex        (graphNext[v])
            );
        end else begin : genDown
            leafEliminationElement #(
                .leafSideCount(aboveCount)
            ) element (
                .vertexPresent     (graphIn[v]),
                .leafSideNeighbors (aboveBits),
                .otherSideNeighbors(belowBits),
                .keepVertex        (graphNext[v])
            );
        end
    end

    // ------------------------------------------------------------------
    // stage register
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            graphOut <= '0;
        end else if (stageEn) begin
            graphOut <= graphNext;    // holds while the strobe is low
        end
    end

endmodule

//--- rtl/leafEliminationElement.sv
module leafEliminationElement #(
    parameter int leafSideCount = 3
) (
    input  logic                                          vertexPresent,
    input  logic [leafSideCount-1:0]                      leafSideNeighbors,
    input  logic [leafElimPkg::dimCount-1-leafSideCount:0] otherSideNeighbors,
    output logic                                          keepVertex
);

    logic anySeen;       // at least one leaf-side neighbor
    logic manySeen;      // two or more leaf-side neighbors
    logic exactlyOne;
    logic otherPresent;
    logic isLeaf;

    // running scan over the leaf side, a second hit marks many
    always_comb begin
        anySeen  = 1'b0;
        manySeen = 1'b0;
        for (int i = 0; i < leafSideCount; i++) begin
            manySeen = manySeen | (anySeen & leafSideNeighbors[i]);
            anySeen  = anySeen | leafSideNeighbors[i];
        end
    end

    assign exactlyOne   = anySeen & ~manySeen;
    assign otherPresent = |otherSideNeighbors;

    // single attachment on the leaf side and nothing on the other side
    assign isLeaf     = exactlyOne & ~otherPresent;
    assign keepVertex = vertexPresent & ~isLeaf;

endmodule

//--- rtl/leafEliminationTop.sv
module leafEliminationTop (
    input  logic               clk,
    input  logic               rstN,
    input  logic               inValid,
    input  leafElimPkg::graphT graphIn,
    output logic               outValid,
    output leafElimPkg::graphT graphOut,
    output logic               isFixedPoint
);

    import leafElimPkg::*;

    // ------------------------------------------------------------------
    // valid chain
    // ------------------------------------------------------------------

    logic [stageCount-1:0] stageValid;     // bit k set while stage k holds a graph
    logic [stageCount-1:0] stageEnable;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stageValid <= '0;
        end else begin
            stageValid <= {stageValid[stageCount-2:0], inValid};
        end
    end

    // each stage loads when the graph ahead of it is valid
    assign stageEnable = {stageValid[stageCount-2:0], inValid};

    // ------------------------------------------------------------------
    // pass pipeline
    // ------------------------------------------------------------------

    graphT stageInput [stageCount];
    graphT stageGraph [stageCount];

    for (genvar k = 0; k < stageCount; k++) begin : genStage
        // even stages prune downward leaves, odd stages upward
        localparam passDirT stageDir = (k % 2 == 0) ? passDown : passUp;

        if (k == 0) begin : genFirst
            assign stageInput[k] = graphIn;
        end else begin : genChain
            assign stageInput[k] = stageGraph[k-1];
        end

        leafElimination #(
            .passDir(stageDir)
        ) stage (
            .clk     (clk),
            .rstN    (rstN),
            .stageEn (stageEnable[k]),
            .graphIn (stageInput[k]),
            .graphOut(stageGraph[k])
        );
    end

    // ------------------------------------------------------------------
    // fixed-point tracking
    // ------------------------------------------------------------------

    // graph entering the last DOWN/UP pair, walked alongside that pair
    localparam int lastPairTap = stageCount - 3;

    graphT pairEntryCopy;
    graphT pairEntryDelay;

    always_ff @(posedge clk) begin
        if (stageValid[lastPairTap]) begin
            pairEntryCopy <= stageGraph[lastPairTap];     // moves with stage 6
        end
        if (stageValid[lastPairTap+1]) begin
            pairEntryDelay <= pairEntryCopy;              // moves with stage 7
        end
    end

    // ------------------------------------------------------------------
    // output register
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= stageValid[stageCount-1];     // one-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (stageValid[stageCount-1]) begin
            graphOut     <= stageGraph[stageCount-1];
            // last pair left the graph untouched
            isFixedPoint <= (stageGraph[stageCount-1] == pairEntryDelay);
        end
    end

endmodule

//--- sources.f
+incdir+test
rtl/leafElimPkg.sv
rtl/leafEliminationElement.sv
rtl/leafElimination.sv
rtl/leafEliminationTop.sv
test/leafEliminationTb.sv

//--- test/leafEliminationRef.svh
`ifndef LEAF_ELIMINATION_REF_SVH
`define LEAF_ELIMINATION_REF_SVH

// ----------------------------------------------------------------------
// reference model of the leaf elimination passes
// ----------------------------------------------------------------------

// one pass, every vertex judged on the incoming word only
function automatic graphT refPass(input graphT graph, input passDirT dir);
    graphT result;
    int    nbr;
    int    aboveCount;
    int    belowCount;
    bit    isLeaf;
    result = graph;
    for (int v = 1; v < graphWidth - 1; v++) begin
        aboveCount = 0;
        belowCount = 0;
        for (int d = 0; d < dimCount; d++) begin
            nbr = v ^ (1 << d);    // flip one index bit
            if (graph[nbr]) begin
                if (nbr > v) begin
                    aboveCount++;
                end else begin
                    belowCount++;
                end
            end
        end
        if (dir == passDown) begin
            isLeaf = (aboveCount == 1) && (belowCount == 0);
        end else begin
            isLeaf = (belowCount == 1) && (aboveCount == 0);
        end
        if (graph[v] && isLeaf) begin
            result[v] = 1'b0;
        end
    end
    return result;
endfunction

// the first count passes of the pipeline, DOWN first
function automatic graphT refPasses(input graphT graph, input int count);
    graphT   work;
    passDirT dir;
    work = graph;
    for (int p = 0; p < count; p++) begin
        dir  = (p % 2 == 0) ? passDown : passUp;
        work = refPass(work, dir);
    end
    return work;
endfunction

function automatic graphT refPipeline(input graphT graph);
    return refPasses(graph, 8);
endfunction

// last DOWN/UP pair changed nothing
function automatic bit refFixed(input graphT graph);
    return refPasses(graph, 6) == refPasses(graph, 8);
endfunction

`endif

//--- test/leafEliminationTb.sv
module leafEliminationTb;

    import leafElimPkg::*;

    `include "leafEliminationRef.svh"

    localparam int randomCount = 200;
    localparam int burstCount  = 24;     // three times the pipeline depth
    localparam int gapCount    = 100;
    localparam int drainLimit  = 64;     // cycles for the pipeline to empty
    localparam int expLatency  = 8;

    logic  clk = 1'b0;
    logic  rstN;
    logic  inValid;
    graphT graphIn;
    logic  outValid;
    graphT graphOut;
    logic  isFixedPoint;

    integer seed       = 32'h511e;
    int     cycleCount = 0;
    string  testName   = "reset";

    // expected results, oldest first
    graphT expGraphQ [$];
    bit    expFixedQ [$];
    int    issueQ [$];
    string nameQ [$];

    int inputCount     = 0;
    int outputCount    = 0;
    int valueErrors    = 0;
    int latencyErrors  = 0;
    int protocolErrors = 0;
    int idleErrors     = 0;
    int modelErrors    = 0;
    int countErrors    = 0;
    int timeoutErrors  = 0;

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    leafEliminationTop DUT (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .graphIn     (graphIn),
        .outValid    (outValid),
        .graphOut    (graphOut),
        .isFixedPoint(isFixedPoint)
    );

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------

    function automatic graphT randomGraph(input bit sparse);
        graphT graph;
        graph = {$random(seed), $random(seed), $random(seed), $random(seed)};
        if (sparse) begin
            graph &= {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        return graph;
    endfunction

    // chain 0, 1, 3, 7 ... 127, one bit added per step
    function automatic graphT pathGraph();
        graphT graph;
        graph = '0;
        for (int k = 0; k <= dimCount; k++) begin
            graph[(1 << k) - 1] = 1'b1;
        end
        return graph;
    endfunction

    // four-vertex chain climbing off vertex 1, one tip lost per UP pass
    function automatic graphT branchGraph();
        graphT graph;
        graph      = pathGraph();
        graph[9]   = 1'b1;    // hangs off vertex 1
        graph[25]  = 1'b1;
        graph[57]  = 1'b1;
        graph[121] = 1'b1;    // tip, gone after the first UP pass
        return graph;
    endfunction

    task automatic driveGraph(input graphT graph);
        @(posedge clk);
        inValid <= 1'b1;
        graphIn <= graph;
    endtask

    task automatic idleCycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            inValid <= 1'b0;
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expGraphQ.size() != 0 && waited < drainLimit) begin
            @(posedge clk);
            waited++;
        end
        if (expGraphQ.size() != 0) begin
            timeoutErrors++;
            $display("ERROR: timeout in %s, %0d graphs still in flight after %0d cycles",
                     testName, expGraphQ.size(), waited);
        end
    endtask

    task automatic sendAndWait(input graphT graph);
        driveGraph(graph);
        idleCycles(1);
        waitDrain();
    endtask

    task automatic checkIdle(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            assert (outValid === 1'b0) else begin
                idleErrors++;
                $display("FAIL %s outValid expected 0 actual %0b", testName, outValid);
            end
        end
    endtask

    // hand-derived results for the fixed graphs
    task automatic checkModel(input string name, input graphT graph, input graphT expGraph,
                              input bit expFixed);
        assert (refPipeline(graph) == expGraph) else begin
            modelErrors++;
            $display("FAIL %s model expected %h actual %h", name, expGraph, refPipeline(graph));
        end
        assert (refFixed(graph) == expFixed) else begin
            modelErrors++;
            $display("FAIL %s model flag expected %0b actual %0b", name, expFixed,
                     refFixed(graph));
        end
    endtask

    // ------------------------------------------------------------------
    // comparison
    // ------------------------------------------------------------------

    always @(negedge clk) begin
        graphT expGraph;
        bit    expFixed;
        int    issue;
        string name;
        if (outValid) begin
            outputCount++;
            if (expGraphQ.size() == 0) begin
                protocolErrors++;
                $display("ERROR: outValid at cycle %0d with no graph in flight", cycleCount);
            end else begin
                expGraph = expGraphQ.pop_front();
                expFixed = expFixedQ.pop_front();
                issue    = issueQ.pop_front();
                name     = nameQ.pop_front();
                assert (graphOut === expGraph) else begin
                    valueErrors++;
                    $display("FAIL %s graph expected %h actual %h", name, expGraph, graphOut);
                end
                assert (isFixedPoint === expFixed) else begin
                    valueErrors++;
                    $display("FAIL %s flag expected %0b actual %0b", name, expFixed,
                             isFixedPoint);
                end
                assert (cycleCount - issue == expLatency) else begin
                    latencyErrors++;
                    $display("FAIL %s latency expected %0d actual %0d", name, expLatency,
                             cycleCount - issue);
                end
            end
        end
        // a strobe seen here is sampled on the coming rising edge
        if (rstN && inValid) begin
            inputCount++;
            expGraphQ.push_back(refPipeline(graphIn));
            expFixedQ.push_back(refFixed(graphIn));
            issueQ.push_back(cycleCount + 1);
            nameQ.push_back(testName);
        end
    end

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------

    initial begin
        int total;
        int gap;
        rstN    <= 1'b0;
        inValid <= 1'b0;
        graphIn <= '0;

        // five rising edges in reset, outValid watched meanwhile
        checkIdle(4);
        @(posedge clk);
        rstN <= 1'b1;
        testName = "idle";
        checkIdle(20);

        checkModel("empty", '0, '0, 1'b1);
        checkModel("full", '1, '1, 1'b1);
        checkModel("path", pathGraph(), pathGraph(), 1'b1);
        checkModel("branch", branchGraph(), pathGraph(), 1'b0);

        testName = "empty";
        sendAndWait('0);
        testName = "full";
        sendAndWait('1);
        testName = "path";
        sendAndWait(pathGraph());
        testName = "branch";
        sendAndWait(branchGraph());

        testName = "random";
        for (int i = 0; i < randomCount; i++) begin
            sendAndWait(randomGraph(i % 2 == 1));
        end

        testName = "burst";
        for (int i = 0; i < burstCount; i++) begin
            driveGraph(randomGraph(i % 2 == 1));
        end
        idleCycles(1);
        waitDrain();

        testName = "gaps";
        for (int i = 0; i < gapCount; i++) begin
            driveGraph(randomGraph(i % 2 == 0));
            gap = {$random(seed)} % 4;     // zero keeps strobes back to back
            idleCycles(gap);
        end
        idleCycles(1);
        waitDrain();

        testName = "tail";
        checkIdle(10);
        assert (outputCount == inputCount) else begin
            countErrors++;
            $display("ERROR: %0d graphs were sent but %0d results came out",
                     inputCount, outputCount);
        end

        total = valueErrors + latencyErrors + protocolErrors + idleErrors + modelErrors
              + countErrors + timeoutErrors;
        $display("errors: value %0d latency %0d protocol %0d idle %0d model %0d count %0d timeout %0d",
                 valueErrors, latencyErrors, protocolErrors, idleErrors, modelErrors,
                 countErrors, timeoutErrors);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
